// File: Makefile
VERILATOR ?= verilator
TOP ?= epu_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/epu_commit.sv
`timescale 1ns/1ns

module epu_commit
#(
   parameter int DW = epu_pkg::DW
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ce,
   input  epu_pkg::commit_t            s2_rec,
   input  logic                        s2_valid,
   input  logic [DW-1:0]               epc,
   output epu_pkg::msr_wr_t            msr_wr,
   output epu_pkg::excp_t              excp,
   output logic                        exc_flush,
   output logic [epu_pkg::PC_W-1:0]    exc_flush_tgt
);
   import epu_pkg::*;

   logic                      commit_go;
   logic                      any_excp;
   msr_we_t                   we;
   logic [DW-1:0]             pc_addr;
   logic [DW-1:0]             npc_addr;
   logic [DW-EXCP_VECT_W-1:0] vect_base;
   logic [PC_W-1:0]           tgt_syscall;
   logic [PC_W-1:0]           tgt_insn;
   logic [PC_W-1:0]           tgt_irq;

   // Record fires once, in a cycle with ce high
   assign commit_go = ce & s2_valid;
   assign any_excp = s2_rec.esyscall | s2_rec.einsn | s2_rec.eirq;

   //////////////////////////////
   // Register writes
   //////////////////////////////

   assign we = commit_go ? s2_rec.we : '0;
   assign msr_wr.we = we;
   assign msr_wr.dat = s2_rec.wdat;

   assign pc_addr = {s2_rec.pc, {INSN_LEN_W{1'b0}}};
   assign npc_addr = {s2_rec.npc, {INSN_LEN_W{1'b0}}};

   //////////////////////////////
   // Save and restore
   //////////////////////////////

   assign excp.save = commit_go & any_excp;
   assign excp.restore = commit_go & s2_rec.eret;

   // Syscall returns past itself, the others retry
   assign excp.epc_nxt = we.epc ? s2_rec.wdat :
                         s2_rec.esyscall ? npc_addr : pc_addr;

   assign excp.set_elsa = commit_go & s2_rec.einsn;
   assign excp.elsa_nxt = s2_rec.einsn ? pc_addr : s2_rec.wdat;

   //////////////////////////////
   // Flush
   //////////////////////////////

   assign vect_base = s2_rec.evect[DW-1:EXCP_VECT_W];
   assign tgt_syscall = {vect_base, VECT_ESYSCALL[EXCP_VECT_W-1:INSN_LEN_W]};
   assign tgt_insn = {vect_base, VECT_EINSN[EXCP_VECT_W-1:INSN_LEN_W]};
   assign tgt_irq = {vect_base, VECT_EIRQ[EXCP_VECT_W-1:INSN_LEN_W]};

   // PSR write refetches from the next insn
   assign exc_flush = commit_go & (any_excp | s2_rec.eret | s2_rec.we.psr);

   assign exc_flush_tgt = ({PC_W{s2_rec.eret}} & epc[DW-1:INSN_LEN_W]) |
                          ({PC_W{s2_rec.we.psr}} & s2_rec.npc) |
                          ({PC_W{s2_rec.esyscall}} & tgt_syscall) |
                          ({PC_W{s2_rec.einsn}} & tgt_insn) |
                          ({PC_W{s2_rec.eirq}} & tgt_irq);

   // Decode hands over at most one exception source
   a_one_excp: assert property (@(posedge clk) disable iff (rst)
      commit_go |-> $onehot0({s2_rec.eret, s2_rec.esyscall, s2_rec.einsn, s2_rec.eirq}));

   // Flush target mux is an OR, so a PSR write must travel alone
   a_psr_alone: assert property (@(posedge clk) disable iff (rst)
      commit_go |-> !(s2_rec.we.psr & (any_excp | s2_rec.eret)));

endmodule

// File: source/epu_decode.sv
`timescale 1ns/1ns

module epu_decode
#(
   parameter int DW = epu_pkg::DW,
   parameter int NUM_IRQ = 8
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ce,
   input  logic                        flush_s1,
   input  logic                        ex_valid,
   input  epu_pkg::epu_op_t            ex_op,
   input  logic [epu_pkg::PC_W-1:0]    ex_pc,
   input  logic [epu_pkg::PC_W-1:0]    ex_npc,
   input  logic [DW-1:0]               ex_operand1,
   input  logic [DW-1:0]               ex_operand2,
   input  logic [DW-1:0]               ex_imm,
   input  epu_pkg::psr_t               psr,
   input  epu_pkg::psr_t               epsr,
   input  logic [DW-1:0]               epc,
   input  logic [DW-1:0]               elsa,
   input  logic [DW-1:0]               evect,
   input  logic [NUM_IRQ-1:0]          imr,
   input  logic [NUM_IRQ-1:0]          irr,
   input  logic [DW-1:0]               tsr,
   input  logic [DW-1:0]               tcr,
   output logic [DW-1:0]               epu_dout,
   output logic                        epu_dout_valid,
   output epu_pkg::commit_t            s2_rec,
   output logic                        s2_valid
);
   import epu_pkg::*;

   logic [DW-1:0]          msr_addr;
   logic [BANK_AW-1:0]     bank;
   logic [BANK_OFF_AW-1:0] off;
   logic                   bank_ps;
   logic                   bank_irqc;
   logic                   bank_tsc;
   logic [DW-1:0]          psr_dw;
   logic [DW-1:0]          epsr_dw;
   logic [DW-1:0]          dout_ps;
   logic [DW-1:0]          dout_irqc;
   logic [DW-1:0]          dout_tsc;
   logic                   accept;
   commit_t                s1_rec;

   //////////////////////////////
   // MSR address
   //////////////////////////////

   assign msr_addr = ex_operand1 | DW'(ex_imm[MSR_ADDR_IMM_W-1:0]);
   assign bank = msr_addr[BANK_AW+BANK_OFF_AW-1:BANK_OFF_AW];
   assign off = msr_addr[BANK_OFF_AW-1:0];

   assign bank_ps = (bank == BANK_PS);
   assign bank_irqc = (bank == BANK_IRQC);
   assign bank_tsc = (bank == BANK_TSC);

   //////////////////////////////
   // Read mux
   //////////////////////////////

   // PSR fields live in bits 9..4
   assign psr_dw = DW'(psr) << PSR_LSB;
   assign epsr_dw = DW'(epsr) << PSR_LSB;

   assign dout_ps = ({DW{off[OFF_PSR]}} & psr_dw) |
                    ({DW{off[OFF_EPSR]}} & epsr_dw) |
                    ({DW{off[OFF_EPC]}} & epc) |
                    ({DW{off[OFF_ELSA]}} & elsa) |
                    ({DW{off[OFF_EVECT]}} & evect);

   assign dout_irqc = ({DW{off[OFF_IMR]}} & DW'(imr)) |
                      ({DW{off[OFF_IRR]}} & DW'(irr));

   assign dout_tsc = ({DW{off[OFF_TSR]}} & tsr) |
                     ({DW{off[OFF_TCR]}} & tcr);

   assign epu_dout = ({DW{bank_ps}} & dout_ps) |
                     ({DW{bank_irqc}} & dout_irqc) |
                     ({DW{bank_tsc}} & dout_tsc);

   assign epu_dout_valid = ex_valid & ex_op.rmsr & ~flush_s1;

   //////////////////////////////
   // Commit record
   //////////////////////////////

   always_comb
   begin
      s1_rec.eret = ex_op.eret;
      s1_rec.esyscall = ex_op.esyscall;
      s1_rec.einsn = ex_op.einsn;
      s1_rec.eirq = ex_op.eirq;
      // IRR has no enable, writes to it are dropped
      s1_rec.we.psr = ex_op.wmsr & bank_ps & off[OFF_PSR];
      s1_rec.we.epc = ex_op.wmsr & bank_ps & off[OFF_EPC];
      s1_rec.we.epsr = ex_op.wmsr & bank_ps & off[OFF_EPSR];
      s1_rec.we.elsa = ex_op.wmsr & bank_ps & off[OFF_ELSA];
      s1_rec.we.evect = ex_op.wmsr & bank_ps & off[OFF_EVECT];
      s1_rec.we.imr = ex_op.wmsr & bank_irqc & off[OFF_IMR];
      s1_rec.we.tsr = ex_op.wmsr & bank_tsc & off[OFF_TSR];
      s1_rec.we.tcr = ex_op.wmsr & bank_tsc & off[OFF_TCR];
      s1_rec.wdat = ex_operand2;
      s1_rec.pc = ex_pc;
      s1_rec.npc = ex_npc;
      s1_rec.evect = evect;
   end

   assign accept = ce & ex_valid & ~flush_s1;

   // Kill wins over hold
   always_ff @(posedge clk)
   begin
      if (rst)
         s2_valid <= 1'b0;
      else if (flush_s1)
         s2_valid <= 1'b0;
      else if (ce)
         s2_valid <= ex_valid;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         s2_rec <= s1_rec;
   end

endmodule

// File: source/epu_irqc.sv
`timescale 1ns/1ns

module epu_irqc
#(
   parameter int DW = epu_pkg::DW,
   parameter int NUM_IRQ = 8
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [NUM_IRQ-1:0]          irqs,
   input  logic                        ire,
   input  epu_pkg::msr_wr_t            msr_wr,
   output logic [NUM_IRQ-1:0]          imr,
   output logic [NUM_IRQ-1:0]          irr,
   output logic                        irq_async
);
   logic [DW-1:0] wr_dat;

   assign wr_dat = msr_wr.dat;

   // IRR samples the lines every cycle, IMR only on write
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         imr <= '0;
         irr <= '0;
         irq_async <= 1'b0;
      end
      else
      begin
         irr <= irqs;
         if (msr_wr.we.imr)
            imr <= wr_dat[NUM_IRQ-1:0];
         irq_async <= ire & (|(irr & imr));
      end
   end

endmodule

// File: source/epu_msr_file.sv
`timescale 1ns/1ns

module epu_msr_file
#(
   parameter int DW = epu_pkg::DW
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  epu_pkg::msr_wr_t            msr_wr,
   input  epu_pkg::excp_t              excp,
   output epu_pkg::psr_t               psr,
   output epu_pkg::psr_t               epsr,
   output logic [DW-1:0]               epc,
   output logic [DW-1:0]               elsa,
   output logic [DW-1:0]               evect
);
   import epu_pkg::*;

   // Out of reset in kernel mode, everything else off
   localparam psr_t PSR_RESET = psr_t'(6'b000001);

   psr_t wr_psr;

   // Data bits 9..4 carry the PSR layout
   assign wr_psr = psr_t'(msr_wr.dat[PSR_LSB +: PSR_W]);

   //////////////////////////////
   // PSR and EPSR
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         psr <= PSR_RESET;
      else if (excp.save)
      begin
         // Enter handler, mask IRQs
         psr.rm <= 1'b1;
         psr.ire <= 1'b0;
      end
      else if (excp.restore)
         psr <= epsr;
      else if (msr_wr.we.psr)
         psr <= wr_psr;
   end

   always_ff @(posedge clk)
   begin
      if (excp.save)
         epsr <= psr;
      else if (msr_wr.we.epsr)
         epsr <= wr_psr;
   end

   //////////////////////////////
   // EPC, ELSA, EVECT
   //////////////////////////////

   // Commit already picked the source
   always_ff @(posedge clk)
   begin
      if (excp.save | msr_wr.we.epc)
         epc <= excp.epc_nxt;
      if (excp.set_elsa | msr_wr.we.elsa)
         elsa <= excp.elsa_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         evect <= '0;
      else if (msr_wr.we.evect)
         evect <= msr_wr.dat;
   end

   a_save_xor_restore: assert property (@(posedge clk) disable iff (rst)
      !(excp.save && excp.restore));

endmodule

// File: source/epu_pkg.sv
package epu_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int DW = 32;
   localparam int MSR_ADDR_IMM_W = 15;
   localparam int BANK_OFF_AW = 9;
   // Bank field sits in address bits 13..9
   localparam int BANK_AW = 5;
   localparam int PSR_LSB = 4;
   localparam int PSR_W = 6;
   localparam int INSN_LEN_W = 2;
   localparam int PC_W = DW - INSN_LEN_W;
   localparam int EXCP_VECT_W = 8;

   //////////////////////////////
   // MSR banks and offsets
   //////////////////////////////

   localparam logic [BANK_AW-1:0] BANK_PS = 5'd0;
   localparam logic [BANK_AW-1:0] BANK_IRQC = 5'd1;
   localparam logic [BANK_AW-1:0] BANK_TSC = 5'd2;

   // Bank PS, one-hot offset bits
   localparam int OFF_PSR = 0;
   localparam int OFF_EPSR = 2;
   localparam int OFF_EPC = 3;
   localparam int OFF_ELSA = 4;
   localparam int OFF_EVECT = 5;

   // Bank IRQC
   localparam int OFF_IMR = 0;
   localparam int OFF_IRR = 1;

   // Bank TSC
   localparam int OFF_TSR = 0;
   localparam int OFF_TCR = 1;

   // Vector offsets below EVECT[31:8]
   localparam logic [EXCP_VECT_W-1:0] VECT_EINSN = 8'h10;
   localparam logic [EXCP_VECT_W-1:0] VECT_ESYSCALL = 8'h20;
   localparam logic [EXCP_VECT_W-1:0] VECT_EIRQ = 8'h30;

   // TCR layout
   localparam int TCR_EN_BIT = 31;
   localparam int TCR_I_BIT = 30;
   localparam int TCR_CNT_W = 28;

   //////////////////////////////
   // Structs
   //////////////////////////////

   typedef struct packed {
      logic rmsr;
      logic wmsr;
      logic eret;
      logic esyscall;
      logic einsn;
      logic eirq;
   } epu_op_t;

   typedef struct packed {
      logic dce;
      logic ice;
      logic dmme;
      logic imme;
      logic ire;
      logic rm;
   } psr_t;

   typedef struct packed {
      logic psr;
      logic epc;
      logic epsr;
      logic elsa;
      logic evect;
      logic imr;
      logic tsr;
      logic tcr;
   } msr_we_t;

   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eirq;
      msr_we_t we;
      logic [DW-1:0] wdat;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc;
      logic [DW-1:0] evect;
   } commit_t;

   typedef struct packed {
      msr_we_t we;
      logic [DW-1:0] dat;
   } msr_wr_t;

   typedef struct packed {
      logic save;
      logic restore;
      logic [DW-1:0] epc_nxt;
      logic [DW-1:0] elsa_nxt;
      logic set_elsa;
   } excp_t;

endpackage

// File: source/epu_top.sv
`timescale 1ns/1ns

module epu_top
#(
   parameter int DW = epu_pkg::DW,
   parameter int NUM_IRQ = 8
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ce,
   input  logic                        flush_s1,
   input  logic                        ex_valid,
   input  epu_pkg::epu_op_t            ex_op,
   input  logic [epu_pkg::PC_W-1:0]    ex_pc,
   input  logic [epu_pkg::PC_W-1:0]    ex_npc,
   input  logic [DW-1:0]               ex_operand1,
   input  logic [DW-1:0]               ex_operand2,
   input  logic [DW-1:0]               ex_imm,
   input  logic [NUM_IRQ-1:0]          irqs,
   output logic [DW-1:0]               epu_dout,
   output logic                        epu_dout_valid,
   output logic                        exc_flush,
   output logic [epu_pkg::PC_W-1:0]    exc_flush_tgt,
   output logic                        irq_async,
   output logic                        tsc_irq
);
   import epu_pkg::*;

   commit_t             s2_rec;
   logic                s2_valid;
   msr_wr_t             msr_wr;
   excp_t               excp;
   psr_t                psr;
   psr_t                epsr;
   logic [DW-1:0]       epc;
   logic [DW-1:0]       elsa;
   logic [DW-1:0]       evect;
   logic [NUM_IRQ-1:0]  imr;
   logic [NUM_IRQ-1:0]  irr;
   logic [DW-1:0]       tsr;
   logic [DW-1:0]       tcr;

   // Stage 1
   epu_decode #(.DW(DW), .NUM_IRQ(NUM_IRQ)) u_decode (
      .clk(clk), .rst(rst), .ce(ce), .flush_s1(flush_s1),
      .ex_valid(ex_valid), .ex_op(ex_op), .ex_pc(ex_pc), .ex_npc(ex_npc),
      .ex_operand1(ex_operand1), .ex_operand2(ex_operand2), .ex_imm(ex_imm),
      .psr(psr), .epsr(epsr), .epc(epc), .elsa(elsa), .evect(evect),
      .imr(imr), .irr(irr), .tsr(tsr), .tcr(tcr),
      .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
      .s2_rec(s2_rec), .s2_valid(s2_valid)
   );

   // Stage 2
   epu_commit #(.DW(DW)) u_commit (
      .clk(clk), .rst(rst), .ce(ce), .s2_rec(s2_rec), .s2_valid(s2_valid),
      .epc(epc), .msr_wr(msr_wr), .excp(excp),
      .exc_flush(exc_flush), .exc_flush_tgt(exc_flush_tgt)
   );

   epu_msr_file #(.DW(DW)) u_msr_file (
      .clk(clk), .rst(rst), .msr_wr(msr_wr), .excp(excp),
      .psr(psr), .epsr(epsr), .epc(epc), .elsa(elsa), .evect(evect)
   );

   epu_irqc #(.DW(DW), .NUM_IRQ(NUM_IRQ)) u_irqc (
      .clk(clk), .rst(rst), .irqs(irqs), .ire(psr.ire), .msr_wr(msr_wr),
      .imr(imr), .irr(irr), .irq_async(irq_async)
   );

   epu_tsc #(.DW(DW)) u_tsc (
      .clk(clk), .rst(rst), .msr_wr(msr_wr),
      .tsr(tsr), .tcr(tcr), .tsc_irq(tsc_irq)
   );

endmodule

// File: source/epu_tsc.sv
`timescale 1ns/1ns

module epu_tsc
#(
   parameter int DW = epu_pkg::DW
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  epu_pkg::msr_wr_t            msr_wr,
   output logic [DW-1:0]               tsr,
   output logic [DW-1:0]               tcr,
   output logic                        tsc_irq
);
   import epu_pkg::*;

   logic cnt_en;
   logic hit;

   assign cnt_en = tcr[TCR_EN_BIT];
   assign hit = cnt_en & tcr[TCR_I_BIT] &
                (tsr[TCR_CNT_W-1:0] == tcr[TCR_CNT_W-1:0]);

   // Write takes priority over counting
   always_ff @(posedge clk)
   begin
      if (rst)
         tsr <= '0;
      else if (msr_wr.we.tsr)
         tsr <= msr_wr.dat;
      else if (cnt_en)
         tsr <= tsr + 1'b1;
   end

   // Sticky until the next TCR write
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tcr <= '0;
         tsc_irq <= 1'b0;
      end
      else if (msr_wr.we.tcr)
      begin
         tcr <= msr_wr.dat;
         tsc_irq <= 1'b0;
      end
      else if (hit)
         tsc_irq <= 1'b1;
   end

endmodule

// File: verification/epu_tb.sv
`timescale 1ns/1ns

module epu_tb;
   import epu_pkg::*;

   localparam int NUM_IRQ = 8;
   localparam int TIMEOUT = 64;

   // One-hot op codes with rmsr as the top bit
   localparam epu_op_t OP_RMSR = epu_op_t'(6'b100000);
   localparam epu_op_t OP_WMSR = epu_op_t'(6'b010000);
   localparam epu_op_t OP_ERET = epu_op_t'(6'b001000);
   localparam epu_op_t OP_SYSCALL = epu_op_t'(6'b000100);
   localparam epu_op_t OP_EINSN = epu_op_t'(6'b000010);

   logic                clk;
   logic                rst;
   logic                ce;
   logic                flush_s1;
   logic                ex_valid;
   epu_op_t             ex_op;
   logic [PC_W-1:0]     ex_pc;
   logic [PC_W-1:0]     ex_npc;
   logic [DW-1:0]       ex_operand1;
   logic [DW-1:0]       ex_operand2;
   logic [DW-1:0]       ex_imm;
   logic [NUM_IRQ-1:0]  irqs;
   logic [DW-1:0]       epu_dout;
   logic                epu_dout_valid;
   logic                exc_flush;
   logic [PC_W-1:0]     exc_flush_tgt;
   logic                irq_async;
   logic                tsc_irq;

   integer seed;
   integer errors;

   // Expected register contents
   psr_t                psr_m;
   psr_t                epsr_m;
   logic [DW-1:0]       epc_m;
   logic [DW-1:0]       elsa_m;
   logic [DW-1:0]       evect_m;
   logic [NUM_IRQ-1:0]  imr_m;

   tb_clock #(.PERIOD(40), .RST_CYCLES(8)) clk_gen (.clk(clk), .rst(rst));

   epu_top #(.DW(DW), .NUM_IRQ(NUM_IRQ)) dut_i (
      .clk(clk), .rst(rst), .ce(ce), .flush_s1(flush_s1),
      .ex_valid(ex_valid), .ex_op(ex_op), .ex_pc(ex_pc), .ex_npc(ex_npc),
      .ex_operand1(ex_operand1), .ex_operand2(ex_operand2), .ex_imm(ex_imm),
      .irqs(irqs), .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
      .exc_flush(exc_flush), .exc_flush_tgt(exc_flush_tgt),
      .irq_async(irq_async), .tsc_irq(tsc_irq)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [DW-1:0] msr_addr(input logic [BANK_AW-1:0] bank, input int off);
      msr_addr = (DW'(bank) << BANK_OFF_AW) | (DW'(1) << off);
   endfunction

   function automatic logic [DW-1:0] psr_word(input psr_t p);
      psr_word = DW'(p) << PSR_LSB;
   endfunction

   function automatic logic [DW-1:0] next_random();
      next_random = $random(seed);
   endfunction

   function automatic logic irq_line(input string name);
      irq_line = (name == "tsc_irq") ? tsc_irq : irq_async;
   endfunction

   task automatic check_value(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic drive_op(input epu_op_t op, input logic [DW-1:0] addr,
                           input logic [DW-1:0] dat, input logic [PC_W-1:0] pc,
                           input logic [PC_W-1:0] npc);
      @(negedge clk);
      ex_valid = 1'b1;
      ex_op = op;
      // Bank goes in operand1 and offset in the immediate
      ex_operand1 = {addr[DW-1:BANK_OFF_AW], {BANK_OFF_AW{1'b0}}};
      ex_imm = {{(DW-BANK_OFF_AW){1'b0}}, addr[BANK_OFF_AW-1:0]};
      ex_operand2 = dat;
      ex_pc = pc;
      ex_npc = npc;
   endtask

   task automatic go_idle();
      @(negedge clk);
      ex_valid = 1'b0;
      ex_op = '0;
      flush_s1 = 1'b0;
   endtask

   task automatic write_msr(input logic [DW-1:0] addr, input logic [DW-1:0] dat);
      drive_op(OP_WMSR, addr, dat, '0, '0);
      go_idle();
   endtask

   task automatic read_msr(input logic [DW-1:0] addr, output logic [DW-1:0] got);
      drive_op(OP_RMSR, addr, '0, '0, '0);
      #5;
      if (epu_dout_valid !== 1'b1)
      begin
         $display("Read of MSR %h was not flagged valid", addr);
         errors++;
      end
      got = epu_dout;
      go_idle();
   endtask

   task automatic check_msr(input string name, input logic [DW-1:0] addr,
                            input logic [DW-1:0] exp);
      logic [DW-1:0] got;
      read_msr(addr, got);
      check_value(name, got, exp);
   endtask

   // Bounded wait for the commit-cycle flush
   task automatic wait_flush(input logic [PC_W-1:0] exp_tgt);
      int n;
      n = 0;
      #5;
      while (exc_flush !== 1'b1 && n < TIMEOUT)
      begin
         @(negedge clk);
         #5;
         n++;
      end
      if (exc_flush !== 1'b1)
      begin
         $display("Timed out waiting for exc_flush");
         errors++;
      end
      else
         check_value("exc_flush_tgt", DW'(exc_flush_tgt), DW'(exp_tgt));
   endtask

   task automatic commit_flush(input epu_op_t op, input logic [DW-1:0] addr,
                               input logic [DW-1:0] dat, input logic [PC_W-1:0] pc,
                               input logic [PC_W-1:0] npc, input logic [PC_W-1:0] exp_tgt);
      drive_op(op, addr, dat, pc, npc);
      go_idle();
      wait_flush(exp_tgt);
   endtask

   // User mode with IRQs on makes the save visible in PSR
   task automatic enter_user_mode();
      psr_t p;
      logic [DW-1:0] rnd;
      rnd = next_random();
      p = psr_t'(rnd[PSR_LSB +: PSR_W]);
      p.rm = 1'b0;
      p.ire = 1'b1;
      write_msr(msr_addr(BANK_PS, OFF_PSR), psr_word(p));
      psr_m = p;
   endtask

   task automatic wait_irq(input string name, input logic level);
      int n;
      n = 0;
      #5;
      while (irq_line(name) !== level && n < TIMEOUT)
      begin
         @(negedge clk);
         #5;
         n++;
      end
      if (irq_line(name) !== level)
      begin
         $display("Timed out waiting for %s to become %0b", name, level);
         errors++;
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_write_read();
      logic [DW-1:0] val;
      epc_m = next_random();
      write_msr(msr_addr(BANK_PS, OFF_EPC), epc_m);
      check_msr("epc", msr_addr(BANK_PS, OFF_EPC), epc_m);
      elsa_m = next_random();
      write_msr(msr_addr(BANK_PS, OFF_ELSA), elsa_m);
      check_msr("elsa", msr_addr(BANK_PS, OFF_ELSA), elsa_m);
      val = next_random();
      imr_m = val[NUM_IRQ-1:0];
      write_msr(msr_addr(BANK_IRQC, OFF_IMR), val);
      check_msr("imr", msr_addr(BANK_IRQC, OFF_IMR), DW'(imr_m));

      // Killed in stage 1
      drive_op(OP_WMSR, msr_addr(BANK_PS, OFF_EPC), next_random(), '0, '0);
      flush_s1 = 1'b1;
      go_idle();
      check_msr("epc", msr_addr(BANK_PS, OFF_EPC), epc_m);

      // Held in stage 2 with ce low
      val = next_random();
      drive_op(OP_WMSR, msr_addr(BANK_PS, OFF_EPC), val, '0, '0);
      @(negedge clk);
      ex_valid = 1'b0;
      ex_op = '0;
      ce = 1'b0;
      repeat (4)
      begin
         #5;
         if (exc_flush !== 1'b0 || dut_i.msr_wr.we !== msr_we_t'(0))
         begin
            $display("Held write reached the registers while ce was low");
            errors++;
         end
         @(negedge clk);
      end
      ce = 1'b1;
      #5;
      if (dut_i.msr_wr.we.epc !== 1'b1)
      begin
         $display("Held EPC write did not commit when ce returned");
         errors++;
      end
      @(negedge clk);
      #5;
      if (dut_i.msr_wr.we !== msr_we_t'(0))
      begin
         $display("Held EPC write committed more than once");
         errors++;
      end
      epc_m = val;
      check_msr("epc", msr_addr(BANK_PS, OFF_EPC), epc_m);
   endtask

   task automatic test_syscall_einsn();
      logic [DW-1:0] vect_addr;
      logic [DW-1:0] rnd;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc;
      evect_m = next_random();
      write_msr(msr_addr(BANK_PS, OFF_EVECT), evect_m);
      check_msr("evect", msr_addr(BANK_PS, OFF_EVECT), evect_m);

      enter_user_mode();
      rnd = next_random();
      pc = rnd[PC_W-1:0];
      npc = pc + PC_W'(1);
      vect_addr = {evect_m[DW-1:EXCP_VECT_W], VECT_ESYSCALL};
      commit_flush(OP_SYSCALL, '0, '0, pc, npc, vect_addr[DW-1:INSN_LEN_W]);
      epsr_m = psr_m;
      psr_m.rm = 1'b1;
      psr_m.ire = 1'b0;
      epc_m = {npc, {INSN_LEN_W{1'b0}}};
      check_msr("epc", msr_addr(BANK_PS, OFF_EPC), epc_m);
      check_msr("epsr", msr_addr(BANK_PS, OFF_EPSR), psr_word(epsr_m));
      check_msr("psr", msr_addr(BANK_PS, OFF_PSR), psr_word(psr_m));

      // Illegal insn also records the faulting address
      enter_user_mode();
      rnd = next_random();
      pc = rnd[PC_W-1:0];
      npc = pc + PC_W'(1);
      vect_addr = {evect_m[DW-1:EXCP_VECT_W], VECT_EINSN};
      commit_flush(OP_EINSN, '0, '0, pc, npc, vect_addr[DW-1:INSN_LEN_W]);
      epsr_m = psr_m;
      psr_m.rm = 1'b1;
      psr_m.ire = 1'b0;
      epc_m = {pc, {INSN_LEN_W{1'b0}}};
      elsa_m = epc_m;
      check_msr("epc", msr_addr(BANK_PS, OFF_EPC), epc_m);
      check_msr("elsa", msr_addr(BANK_PS, OFF_ELSA), elsa_m);
      check_msr("epsr", msr_addr(BANK_PS, OFF_EPSR), psr_word(epsr_m));
      check_msr("psr", msr_addr(BANK_PS, OFF_PSR), psr_word(psr_m));
   endtask

   task automatic test_eret();
      logic [DW-1:0] val;
      val = next_random();
      // EPSR in user mode makes the restore visible
      val[PSR_LSB] = 1'b0;
      epsr_m = psr_t'(val[PSR_LSB +: PSR_W]);
      write_msr(msr_addr(BANK_PS, OFF_EPSR), val);
      epc_m = next_random();
      write_msr(msr_addr(BANK_PS, OFF_EPC), epc_m);
      commit_flush(OP_ERET, '0, '0, '0, '0, epc_m[DW-1:INSN_LEN_W]);
      psr_m = epsr_m;
      check_msr("psr", msr_addr(BANK_PS, OFF_PSR), psr_word(psr_m));
   endtask

   task automatic test_psr_write();
      logic [DW-1:0] val;
      logic [DW-1:0] rnd;
      val = next_random();
      rnd = next_random();
      commit_flush(OP_WMSR, msr_addr(BANK_PS, OFF_PSR), val, rnd[PC_W-1:0] - PC_W'(1),
                   rnd[PC_W-1:0], rnd[PC_W-1:0]);
      psr_m = psr_t'(val[PSR_LSB +: PSR_W]);
      check_msr("psr", msr_addr(BANK_PS, OFF_PSR), psr_word(psr_m));
   endtask

   task automatic test_irq();
      psr_t p;
      logic [NUM_IRQ-1:0] lines;
      imr_m = NUM_IRQ'(8'h5A);
      write_msr(msr_addr(BANK_IRQC, OFF_IMR), DW'(imr_m));
      p = '0;
      p.rm = 1'b1;
      p.ire = 1'b1;
      commit_flush(OP_WMSR, msr_addr(BANK_PS, OFF_PSR), psr_word(p), '0, PC_W'(4),
                   PC_W'(4));
      psr_m = p;
      lines = NUM_IRQ'(8'h12);
      @(negedge clk);
      irqs = lines;
      wait_irq("irq_async", 1'b1);
      check_msr("irr", msr_addr(BANK_IRQC, OFF_IRR), DW'(lines));
      imr_m = '0;
      write_msr(msr_addr(BANK_IRQC, OFF_IMR), '0);
      wait_irq("irq_async", 1'b0);
      @(negedge clk);
      irqs = '0;
   endtask

   task automatic test_timer();
      logic [DW-1:0] tcr_val;
      logic [DW-1:0] t1;
      logic [DW-1:0] t2;
      tcr_val = (DW'(1) << TCR_EN_BIT) | (DW'(1) << TCR_I_BIT) | DW'(5);
      write_msr(msr_addr(BANK_TSC, OFF_TSR), '0);
      write_msr(msr_addr(BANK_TSC, OFF_TCR), tcr_val);
      wait_irq("tsc_irq", 1'b1);
      check_msr("tcr", msr_addr(BANK_TSC, OFF_TCR), tcr_val);
      // Reads sit two cycles apart
      read_msr(msr_addr(BANK_TSC, OFF_TSR), t1);
      read_msr(msr_addr(BANK_TSC, OFF_TSR), t2);
      check_value("tsr", t2, t1 + DW'(2));
      write_msr(msr_addr(BANK_TSC, OFF_TCR), '0);
      wait_irq("tsc_irq", 1'b0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      int n;
      seed = 46;
      errors = 0;
      ce = 1'b1;
      flush_s1 = 1'b0;
      ex_valid = 1'b0;
      ex_op = '0;
      ex_pc = '0;
      ex_npc = '0;
      ex_operand1 = '0;
      ex_operand2 = '0;
      ex_imm = '0;
      irqs = '0;
      psr_m = psr_t'(6'b000001);

      n = 0;
      while (rst !== 1'b0 && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (rst !== 1'b0)
      begin
         $display("Reset was never released");
         errors++;
      end

      // Reset state
      #5;
      if (exc_flush !== 1'b0 || irq_async !== 1'b0 || tsc_irq !== 1'b0)
      begin
         $display("Outputs not idle after reset");
         errors++;
      end
      check_msr("psr", msr_addr(BANK_PS, OFF_PSR), psr_word(psr_m));
      check_msr("evect", msr_addr(BANK_PS, OFF_EVECT), '0);
      check_msr("imr", msr_addr(BANK_IRQC, OFF_IMR), '0);
      check_msr("tsr", msr_addr(BANK_TSC, OFF_TSR), '0);
      check_msr("tcr", msr_addr(BANK_TSC, OFF_TCR), '0);

      test_write_read();
      test_syscall_einsn();
      test_eret();
      test_psr_write();
      test_irq();
      test_timer();

      $display("Checks finished with %0d errors", errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
#(
   parameter int PERIOD = 40,
   parameter int RST_CYCLES = 8
)
(
   output logic clk,
   output logic rst
);
   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;
   end

   // Release away from the rising edge
   initial
   begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// File: verilog.f
source/epu_pkg.sv
source/epu_decode.sv
source/epu_commit.sv
source/epu_msr_file.sv
source/epu_irqc.sv
source/epu_tsc.sv
source/epu_top.sv
verification/tb_clock.sv
verification/epu_tb.sv
